/* logic/mm_cfg_pkg.sv */
/*
 * matrix-multiply configuration
 * dimension, element, accumulator and index types shared by
 * the DMA engine and the multiply array
 */
package mm_cfg_pkg;

    // square matrices only
    localparam int MAT_DIM   = 4;
    localparam int MAT_ELEMS = MAT_DIM * MAT_DIM;

    // bit widths
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 32;

    // signed input element, taken from bits 7:0 of a memory word
    typedef logic signed [ELEM_W-1:0] elem_t;
    // signed result element, wide enough for any 4-term sum
    typedef logic signed [ACC_W-1:0] acc_t;
    // row-major element index
    typedef logic [$clog2(MAT_ELEMS)-1:0] elem_idx_t;
    // multiply step counter, one step per k
    typedef logic [$clog2(MAT_DIM)-1:0] step_t;

endpackage

/* logic/mem_bus_pkg.sv */
/*
 * shared memory bus definitions
 * address and word types, memory depth and requester encoding
 */
package mem_bus_pkg;

    localparam int MEM_DEPTH = 1024;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);
    localparam int WORD_W    = 32;

    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [WORD_W-1:0] mem_word_t;

    // peers on the shared port
    typedef enum logic {HOST = 1'b0, DMA = 1'b1} requester_t;

endpackage

/* logic/mem_bus_if.sv */
/*
 * word request bus
 * request/grant with one-cycle read latency, used between a
 * requester, the arbiter and the memory
 */
`timescale 1ns/10ps

interface mem_bus_if ();

    // request side, held until gnt
    logic                  req;
    logic                  we;
    mem_bus_pkg::mem_addr_t addr;
    mem_bus_pkg::mem_word_t wdata;
    // response side
    logic                  gnt;
    logic                  rvalid;
    mem_bus_pkg::mem_word_t rdata;

    modport requester (output req, we, addr, wdata, input gnt, rvalid, rdata);
    modport arbiter (input req, we, addr, wdata, output gnt, rvalid, rdata);
    modport memory (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

/* logic/mm_ctrl_if.sv */
/*
 * multiply array control
 * operand load, start/done pulses and result readout between
 * the DMA engine and the multiply array
 */
`timescale 1ns/10ps

interface mm_ctrl_if ();

    // operand load port, one element per cycle
    logic                  ld_we;
    logic                  ld_sel_b;
    mm_cfg_pkg::elem_idx_t ld_idx;
    mm_cfg_pkg::elem_t     ld_data;
    // one-cycle pulses
    logic                  start;
    logic                  done;
    // result readout, combinational
    mm_cfg_pkg::elem_idx_t c_idx;
    mm_cfg_pkg::acc_t      c_data;

    modport engine (output ld_we, ld_sel_b, ld_idx, ld_data, start, c_idx,
                    input done, c_data);
    modport array (input ld_we, ld_sel_b, ld_idx, ld_data, start, c_idx,
                   output done, c_data);

endinterface

/* logic/mem_arbiter.sv */
/*
 * round-robin memory arbiter
 * merges host and DMA requests onto the single memory port and
 * returns read data only to the requester that owned the read
 */
`timescale 1ns/10ps

module mem_arbiter (
    input logic           clk,
    input logic           rst_n,
    mem_bus_if.arbiter    host_bus,
    mem_bus_if.arbiter    dma_bus,
    mem_bus_if.requester  mem_bus
);

    mem_bus_pkg::requester_t sel;
    mem_bus_pkg::requester_t last_winner;
    mem_bus_pkg::requester_t rd_owner;

    // tie goes to whoever lost last time
    always_comb begin
        if (host_bus.req && dma_bus.req) begin
            sel = (last_winner == mem_bus_pkg::HOST) ? mem_bus_pkg::DMA : mem_bus_pkg::HOST;
        end else if (dma_bus.req) begin
            sel = mem_bus_pkg::DMA;
        end else begin
            sel = mem_bus_pkg::HOST;
        end
    end

    // forward the winner
    assign mem_bus.req   = host_bus.req | dma_bus.req;
    assign mem_bus.we    = (sel == mem_bus_pkg::DMA) ? dma_bus.we : host_bus.we;
    assign mem_bus.addr  = (sel == mem_bus_pkg::DMA) ? dma_bus.addr : host_bus.addr;
    assign mem_bus.wdata = (sel == mem_bus_pkg::DMA) ? dma_bus.wdata : host_bus.wdata;

    // grant in the same cycle
    assign host_bus.gnt = mem_bus.gnt && host_bus.req && (sel == mem_bus_pkg::HOST);
    assign dma_bus.gnt  = mem_bus.gnt && dma_bus.req && (sel == mem_bus_pkg::DMA);

    // read data is shared, valid is steered
    assign host_bus.rdata  = mem_bus.rdata;
    assign dma_bus.rdata   = mem_bus.rdata;
    assign host_bus.rvalid = mem_bus.rvalid && (rd_owner == mem_bus_pkg::HOST);
    assign dma_bus.rvalid  = mem_bus.rvalid && (rd_owner == mem_bus_pkg::DMA);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // host wins the first tie
            last_winner <= mem_bus_pkg::DMA;
            rd_owner    <= mem_bus_pkg::HOST;
        end else if (mem_bus.req && mem_bus.gnt) begin
            last_winner <= sel;
            // owner of the read whose data comes back next cycle
            if (!mem_bus.we) begin
                rd_owner <= sel;
            end
        end
    end

endmodule

/* logic/shared_sram.sv */
/*
 * shared word memory
 * single port, grants every request, read data one cycle later
 */
`timescale 1ns/10ps

module shared_sram (
    input logic        clk,
    mem_bus_if.memory  bus_if
);

    mem_bus_pkg::mem_word_t mem [mem_bus_pkg::MEM_DEPTH];

    // no contention behind the arbiter
    assign bus_if.gnt = bus_if.req;

    always_ff @(posedge clk) begin
        if (bus_if.req && bus_if.we) begin
            mem[bus_if.addr] <= bus_if.wdata;
        end
        if (bus_if.req && !bus_if.we) begin
            bus_if.rdata <= mem[bus_if.addr];
        end
    end

    // valid tracks last cycle's read grant
    always_ff @(posedge clk) begin
        bus_if.rvalid <= bus_if.req && bus_if.gnt && !bus_if.we;
    end

endmodule

/* logic/dma_engine.sv */
/*
 * DMA engine
 * reads A and B into the multiply array, starts it, waits for
 * done and writes the 16 results of C back to memory
 */
`timescale 1ns/10ps

module dma_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_bus_pkg::mem_addr_t a_base_i,
    input  mem_bus_pkg::mem_addr_t b_base_i,
    input  mem_bus_pkg::mem_addr_t c_base_i,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   done_o,
    mem_bus_if.requester           bus_if,
    mm_ctrl_if.engine              mm_if
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        START_MM,
        WAIT_MM,
        STORE,
        FINISH
    } dma_state_t;

    dma_state_t state;

    // latched job addresses
    mem_bus_pkg::mem_addr_t a_base;
    mem_bus_pkg::mem_addr_t b_base;
    mem_bus_pkg::mem_addr_t c_base;

    // issued reads 0..32, bit 4 picks B
    logic [5:0] rq_cnt;
    // returned reads 0..31
    logic [4:0] rd_cnt;
    // stored results
    mm_cfg_pkg::elem_idx_t st_cnt;

    logic rd_pending;
    mm_cfg_pkg::elem_idx_t rq_idx;

    assign rd_pending = (rq_cnt < 6'(2 * mm_cfg_pkg::MAT_ELEMS));
    assign rq_idx     = rq_cnt[3:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            rq_cnt <= '0;
            rd_cnt <= '0;
            st_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state  <= LOAD;
                        rq_cnt <= '0;
                        rd_cnt <= '0;
                        st_cnt <= '0;
                    end
                end
                LOAD: begin
                    // requests and returns overlap
                    if (bus_if.req && bus_if.gnt) begin
                        rq_cnt <= rq_cnt + 6'd1;
                    end
                    if (bus_if.rvalid) begin
                        rd_cnt <= rd_cnt + 5'd1;
                        if (rd_cnt == 5'(2 * mm_cfg_pkg::MAT_ELEMS - 1)) begin
                            state <= START_MM;
                        end
                    end
                end
                START_MM: state <= WAIT_MM;
                WAIT_MM: begin
                    if (mm_if.done) begin
                        state <= STORE;
                    end
                end
                STORE: begin
                    if (bus_if.gnt) begin
                        st_cnt <= st_cnt + 1'b1;
                        if (st_cnt == mm_cfg_pkg::elem_idx_t'(mm_cfg_pkg::MAT_ELEMS - 1)) begin
                            state <= FINISH;
                        end
                    end
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // bases held for the whole job
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            a_base <= a_base_i;
            b_base <= b_base_i;
            c_base <= c_base_i;
        end
    end

    always_comb begin
        bus_if.req   = 1'b0;
        bus_if.we    = 1'b0;
        bus_if.addr  = c_base + mem_bus_pkg::mem_addr_t'(st_cnt);
        bus_if.wdata = mem_bus_pkg::mem_word_t'(mm_if.c_data);
        if (state == LOAD) begin
            bus_if.req  = rd_pending;
            bus_if.addr = (rq_cnt[4] ? b_base : a_base) + mem_bus_pkg::mem_addr_t'(rq_idx);
        end else if (state == STORE) begin
            bus_if.req = 1'b1;
            bus_if.we  = 1'b1;
        end
    end

    // returned words go straight into the operand registers
    assign mm_if.ld_we    = (state == LOAD) && bus_if.rvalid;
    assign mm_if.ld_sel_b = rd_cnt[4];
    assign mm_if.ld_idx   = rd_cnt[3:0];
    // upper word bits ignored
    assign mm_if.ld_data  = mm_cfg_pkg::elem_t'(bus_if.rdata[7:0]);
    assign mm_if.start    = (state == START_MM);
    assign mm_if.c_idx    = st_cnt;

    assign busy_o = (state != IDLE);
    assign done_o = (state == FINISH);

endmodule

/* logic/mm_array.sv */
/*
 * 4x4 multiply array
 * operand registers and 16 accumulators, one k term per cycle
 * in parallel, done four cycles after start
 */
`timescale 1ns/10ps

module mm_array (
    input logic       clk,
    input logic       rst_n,
    mm_ctrl_if.array  mm_if
);

    mm_cfg_pkg::elem_t a_reg [mm_cfg_pkg::MAT_ELEMS];
    mm_cfg_pkg::elem_t b_reg [mm_cfg_pkg::MAT_ELEMS];
    mm_cfg_pkg::acc_t  acc   [mm_cfg_pkg::MAT_ELEMS];

    logic              run;
    mm_cfg_pkg::step_t step;
    mm_cfg_pkg::step_t k;

    // start edge handles k=0, run edges k=1..3
    assign k = mm_if.start ? '0 : step;

    // operand load from the DMA engine
    always_ff @(posedge clk) begin
        if (mm_if.ld_we) begin
            if (mm_if.ld_sel_b) begin
                b_reg[mm_if.ld_idx] <= mm_if.ld_data;
            end else begin
                a_reg[mm_if.ld_idx] <= mm_if.ld_data;
            end
        end
    end

    // step sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run        <= 1'b0;
            step       <= '0;
            mm_if.done <= 1'b0;
        end else begin
            mm_if.done <= 1'b0;
            if (mm_if.start) begin
                run  <= 1'b1;
                step <= mm_cfg_pkg::step_t'(1);
            end else if (run) begin
                step <= step + 1'b1;
                // last term lands on this edge
                if (step == mm_cfg_pkg::step_t'(mm_cfg_pkg::MAT_DIM - 1)) begin
                    run        <= 1'b0;
                    mm_if.done <= 1'b1;
                end
            end
        end
    end

    // every C(i,j) adds A(i,k)*B(k,j) in the same cycle
    // start replaces the old sum, which clears it
    always_ff @(posedge clk) begin
        for (int i = 0; i < mm_cfg_pkg::MAT_DIM; i++) begin
            for (int j = 0; j < mm_cfg_pkg::MAT_DIM; j++) begin
                if (mm_if.start || run) begin
                    acc[i*mm_cfg_pkg::MAT_DIM + j] <=
                        (mm_if.start ? mm_cfg_pkg::acc_t'(0) : acc[i*mm_cfg_pkg::MAT_DIM + j])
                        + mm_cfg_pkg::acc_t'(a_reg[i*mm_cfg_pkg::MAT_DIM + int'(k)])
                        * mm_cfg_pkg::acc_t'(b_reg[int'(k)*mm_cfg_pkg::MAT_DIM + j]);
                end
            end
        end
    end

    // result readout for the store phase
    assign mm_if.c_data = acc[mm_if.c_idx];

endmodule

/* logic/mm_top.sv */
/*
 * matrix-multiply accelerator top
 * host port, arbiter, shared memory, DMA engine and multiply array
 */
`timescale 1ns/10ps

module mm_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // host bus
    input  logic                   host_req_i,
    input  logic                   host_we_i,
    input  mem_bus_pkg::mem_addr_t host_addr_i,
    input  mem_bus_pkg::mem_word_t host_wdata_i,
    output logic                   host_gnt_o,
    output logic                   host_rvalid_o,
    output mem_bus_pkg::mem_word_t host_rdata_o,
    // job control
    input  mem_bus_pkg::mem_addr_t a_base_i,
    input  mem_bus_pkg::mem_addr_t b_base_i,
    input  mem_bus_pkg::mem_addr_t c_base_i,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   done_o
);

    mem_bus_if host_bus ();
    mem_bus_if dma_bus ();
    mem_bus_if mem_bus ();
    mm_ctrl_if mm_if ();

    // host pins onto the host bus
    assign host_bus.req   = host_req_i;
    assign host_bus.we    = host_we_i;
    assign host_bus.addr  = host_addr_i;
    assign host_bus.wdata = host_wdata_i;
    assign host_gnt_o     = host_bus.gnt;
    assign host_rvalid_o  = host_bus.rvalid;
    assign host_rdata_o   = host_bus.rdata;

    mem_arbiter arb_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_bus (host_bus.arbiter),
        .dma_bus  (dma_bus.arbiter),
        .mem_bus  (mem_bus.requester)
    );

    shared_sram sram_i (
        .clk    (clk),
        .bus_if (mem_bus.memory)
    );

    dma_engine dma_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_base_i (a_base_i),
        .b_base_i (b_base_i),
        .c_base_i (c_base_i),
        .start_i  (start_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .bus_if   (dma_bus.requester),
        .mm_if    (mm_if.engine)
    );

    mm_array array_i (
        .clk   (clk),
        .rst_n (rst_n),
        .mm_if (mm_if.array)
    );

endmodule

/* verification/mm_properties.sv */
/*
 * accelerator properties
 * host grant, host read data and done pulse rules on the top level
 */
`timescale 1ns/10ps

module mm_properties (
    input logic clk,
    input logic rst_n,
    input logic host_req_i,
    input logic host_we_i,
    input logic host_gnt_i,
    input logic host_rvalid_i,
    input logic busy_i,
    input logic done_i
);

    // grant only answers a request
    gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        host_gnt_i |-> host_req_i)
        else $error("host grant without a host request");

    // read data one cycle after a granted host read
    rvalid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        host_rvalid_i |-> $past(host_gnt_i && !host_we_i))
        else $error("host read valid without a granted host read");

    // single-cycle done that ends a busy stretch
    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> ($past(busy_i) && !$past(done_i)))
        else $error("done longer than one cycle or outside a job");

endmodule

bind mm_top mm_properties props_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_req_i    (host_req_i),
    .host_we_i     (host_we_i),
    .host_gnt_i    (host_gnt_o),
    .host_rvalid_i (host_rvalid_o),
    .busy_i        (busy_o),
    .done_i        (done_o)
);

/* verification/mm_tb.sv */
/*
 * matrix-multiply accelerator testbench
 * host traffic, random jobs and a reference product check
 */
`timescale 1ns/10ps

module mm_tb;

    localparam int DIM          = mm_cfg_pkg::MAT_DIM;
    localparam int NEL          = mm_cfg_pkg::MAT_ELEMS;
    localparam int GNT_TIMEOUT  = 64;
    localparam int DONE_TIMEOUT = 2000;
    localparam int TRAFFIC_MAX  = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   host_req;
    logic                   host_we;
    mem_bus_pkg::mem_addr_t host_addr;
    mem_bus_pkg::mem_word_t host_wdata;
    logic                   host_gnt;
    logic                   host_rvalid;
    mem_bus_pkg::mem_word_t host_rdata;
    mem_bus_pkg::mem_addr_t a_base;
    mem_bus_pkg::mem_addr_t b_base;
    mem_bus_pkg::mem_addr_t c_base;
    logic                   start;
    logic                   busy;
    logic                   done;

    logic [31:0] lfsr;
    int done_cnt = 0;
    // expected words of outstanding host reads in issue order
    mem_bus_pkg::mem_word_t exp_q [$];
    // what the host last wrote per address
    mem_bus_pkg::mem_word_t shadow [mem_bus_pkg::MEM_DEPTH];

    mm_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_req_i    (host_req),
        .host_we_i     (host_we),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .host_gnt_o    (host_gnt),
        .host_rvalid_o (host_rvalid),
        .host_rdata_o  (host_rdata),
        .a_base_i      (a_base),
        .b_base_i      (b_base),
        .c_base_i      (c_base),
        .start_i       (start),
        .busy_o        (busy),
        .done_o        (done)
    );

    always #50 clk = ~clk;

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_word(input string name, input mem_bus_pkg::mem_word_t got,
                              input mem_bus_pkg::mem_word_t exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // C(i,j) is the signed sum over k of A(i,k) * B(k,j)
    function automatic void ref_matmul(input mm_cfg_pkg::elem_t a [NEL],
                                       input mm_cfg_pkg::elem_t b [NEL],
                                       output mm_cfg_pkg::acc_t c [NEL]);
        mm_cfg_pkg::acc_t sum;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                sum = '0;
                for (int k = 0; k < DIM; k++) begin
                    sum += mm_cfg_pkg::acc_t'(a[i*DIM + k]) * mm_cfg_pkg::acc_t'(b[k*DIM + j]);
                end
                c[i*DIM + j] = sum;
            end
        end
    endfunction

    // request held until granted
    // returns just after the access edge
    task automatic request_access(input logic we, input mem_bus_pkg::mem_addr_t addr,
                                  input mem_bus_pkg::mem_word_t wdata);
        int   n;
        logic granted;
        n          = 0;
        granted    = 1'b0;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        while (!granted) begin
            @(negedge clk);
            granted = host_gnt;
            @(posedge clk);
            #1;
            n++;
            if (!granted && n >= GNT_TIMEOUT) begin
                abort_run("timeout waiting for host grant");
            end
        end
        host_req = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic host_write(input mem_bus_pkg::mem_addr_t addr,
                              input mem_bus_pkg::mem_word_t data);
        request_access(1'b1, addr, data);
        shadow[addr] = data;
    endtask

    // waits until the read data has returned
    task automatic host_read(input mem_bus_pkg::mem_addr_t addr,
                             input mem_bus_pkg::mem_word_t exp);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        exp_q.push_back(exp);
        request_access(1'b0, addr, '0);
        while (!seen) begin
            @(negedge clk);
            seen = host_rvalid;
            @(posedge clk);
            #1;
            n++;
            if (!seen && n >= GNT_TIMEOUT) begin
                abort_run("timeout waiting for host read data");
            end
        end
    endtask

    // compare every returned host word with the oldest expectation
    always @(negedge clk) begin
        if (rst_n && host_rvalid) begin
            if (exp_q.size() == 0) begin
                abort_run("host read data returned with no read outstanding");
            end else begin
                check_word("host_rdata_o", host_rdata, exp_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && done) begin
            done_cnt++;
        end
    end

    task automatic wait_done(input int prev);
        int n;
        n = 0;
        while (done_cnt == prev) begin
            @(posedge clk);
            #1;
            n++;
            if (done_cnt == prev && n >= DONE_TIMEOUT) begin
                abort_run("timeout waiting for done");
            end
        end
    endtask

    task automatic start_job(input mem_bus_pkg::mem_addr_t a, input mem_bus_pkg::mem_addr_t b,
                             input mem_bus_pkg::mem_addr_t c);
        a_base = a;
        b_base = b;
        c_base = c;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // random A and B with random upper word bits plus expected C
    task automatic prepare_job(input mem_bus_pkg::mem_addr_t a, input mem_bus_pkg::mem_addr_t b,
                               output mm_cfg_pkg::acc_t c_ref [NEL]);
        mm_cfg_pkg::elem_t a_m [NEL];
        mm_cfg_pkg::elem_t b_m [NEL];
        logic [31:0]       r;
        for (int i = 0; i < NEL; i++) begin
            take_bits(32, r);
            a_m[i] = mm_cfg_pkg::elem_t'(r[7:0]);
            host_write(a + mem_bus_pkg::mem_addr_t'(i), r);
            take_bits(32, r);
            b_m[i] = mm_cfg_pkg::elem_t'(r[7:0]);
            host_write(b + mem_bus_pkg::mem_addr_t'(i), r);
        end
        ref_matmul(a_m, b_m, c_ref);
    endtask

    task automatic check_results(input mem_bus_pkg::mem_addr_t c,
                                 input mm_cfg_pkg::acc_t c_ref [NEL]);
        for (int i = 0; i < NEL; i++) begin
            host_read(c + mem_bus_pkg::mem_addr_t'(i), mem_bus_pkg::mem_word_t'(c_ref[i]));
        end
    endtask

    initial begin
        mm_cfg_pkg::acc_t       c1 [NEL];
        mm_cfg_pkg::acc_t       c2 [NEL];
        mm_cfg_pkg::acc_t       c3 [NEL];
        mm_cfg_pkg::acc_t       c4 [NEL];
        mem_bus_pkg::mem_addr_t addrs [16];
        mem_bus_pkg::mem_addr_t addr;
        logic [31:0]            r;
        int                     prev;
        int                     iters;
        lfsr       = 32'h394;
        clk        = 1'b0;
        rst_n      = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        a_base     = '0;
        b_base     = '0;
        c_base     = '0;
        start      = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle outputs right after reset
        @(negedge clk);
        check_bit("busy_o", busy, 1'b0);
        check_bit("done_o", done, 1'b0);
        check_bit("host_gnt_o", host_gnt, 1'b0);
        check_bit("host_rvalid_o", host_rvalid, 1'b0);
        @(posedge clk);
        #1;

        // plain host writes and read back in 0x100..0x1ff
        for (int i = 0; i < 16; i++) begin
            take_bits(8, r);
            addrs[i] = 10'h100 | mem_bus_pkg::mem_addr_t'(r);
            take_bits(32, r);
            host_write(addrs[i], r);
        end
        for (int i = 0; i < 16; i++) begin
            host_read(addrs[i], shadow[addrs[i]]);
        end

        // single job with no other traffic
        prepare_job(10'h000, 10'h010, c1);
        prev = done_cnt;
        start_job(10'h000, 10'h010, 10'h020);
        check_bit("busy_o", busy, 1'b1);
        wait_done(prev);
        check_bit("busy_o", busy, 1'b0);
        check_results(10'h020, c1);

        // job with host traffic in 0x200..0x3ff until done
        prepare_job(10'h040, 10'h050, c2);
        prev  = done_cnt;
        iters = 0;
        start_job(10'h040, 10'h050, 10'h060);
        while (done_cnt == prev) begin
            take_bits(9, r);
            addr = 10'h200 | mem_bus_pkg::mem_addr_t'(r);
            take_bits(32, r);
            host_write(addr, r);
            host_read(addr, shadow[addr]);
            iters++;
            if (done_cnt == prev && iters >= TRAFFIC_MAX) begin
                abort_run("timeout waiting for done during host traffic");
            end
        end
        check_results(10'h060, c2);

        // back to back jobs
        // the extra start in the first one is dropped
        prepare_job(10'h080, 10'h090, c3);
        prepare_job(10'h0c0, 10'h0d0, c4);
        prev = done_cnt;
        start_job(10'h080, 10'h090, 10'h0a0);
        repeat (3) @(posedge clk);
        #1;
        start_job(10'h0c0, 10'h0d0, 10'h0e0);
        check_bit("busy_o", busy, 1'b1);
        wait_done(prev);
        check_bit("busy_o", busy, 1'b0);
        start_job(10'h0c0, 10'h0d0, 10'h0e0);
        wait_done(prev + 1);
        check_results(10'h0a0, c3);
        check_results(10'h0e0, c4);

        $display("all tests passed");
        $finish;
    end

endmodule

/* vlog.f */
logic/mm_cfg_pkg.sv
logic/mem_bus_pkg.sv
logic/mem_bus_if.sv
logic/mm_ctrl_if.sv
logic/mem_arbiter.sv
logic/shared_sram.sv
logic/dma_engine.sv
logic/mm_array.sv
logic/mm_top.sv
verification/mm_properties.sv
verification/mm_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := mm_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
